/* compile.f */
+incdir+hw
hw/wasm_isa_pkg.sv
hw/wasm_core_pkg.sv
hw/i32_binary_alu.sv
hw/i32_unary_unit.sv
hw/operand_stack.sv
hw/instr_sequencer.sv
hw/wasm_core_top.sv
dv/tb_checker.sv
dv/tb_top.sv

/* dv/program_golden.mem */
// nbytes start_pc trap result type empty, then nbytes program bytes
// i32.const, one to five byte immediates
3 10 1 00000005 0 0 41 05 0B
3 10 1 FFFFFFFF 0 0 41 7F 0B
4 10 1 FFFFFF38 0 0 41 B8 7E 0B
7 20 1 12345678 0 0 41 F8 AC D1 91 01 0B
7 00 1 80000000 0 0 41 80 80 80 80 78 0B
// binary operators
6 10 1 0000000C 0 0 41 07 41 05 6A 0B
6 10 1 FFFFFFFE 0 0 41 03 41 05 6B 0B
6 10 1 FFFFFFEB 0 0 41 7D 41 07 6C 0B
6 10 1 00000014 0 0 41 35 41 1C 71 0B
6 10 1 0000003D 0 0 41 35 41 1C 72 0B
6 10 1 00000029 0 0 41 35 41 1C 73 0B
6 10 1 0000006A 0 0 41 35 41 21 74 0B
6 10 1 FFFFFFF0 0 0 41 40 41 02 75 0B
6 10 1 3FFFFFF0 0 0 41 40 41 02 76 0B
A 10 1 00000001 0 0 41 80 80 80 80 78 41 21 77 0B
6 10 1 10000000 0 0 41 01 41 24 78 0B
// comparisons of -2 against 3, and an equal pair
6 10 1 00000000 0 0 41 7E 41 03 46 0B
6 10 1 00000001 0 0 41 05 41 05 46 0B
6 10 1 00000001 0 0 41 7E 41 03 47 0B
6 10 1 00000001 0 0 41 7E 41 03 48 0B
6 10 1 00000000 0 0 41 7E 41 03 49 0B
6 10 1 00000000 0 0 41 7E 41 03 4A 0B
6 10 1 00000001 0 0 41 7E 41 03 4B 0B
6 10 1 00000001 0 0 41 7E 41 03 4C 0B
6 10 1 00000000 0 0 41 7E 41 03 4D 0B
6 10 1 00000000 0 0 41 7E 41 03 4E 0B
6 10 1 00000001 0 0 41 7E 41 03 4F 0B
// clz, ctz, popcnt, eqz
4 10 1 00000020 0 0 41 00 67 0B
4 10 1 0000001F 0 0 41 01 67 0B
8 10 1 00000000 0 0 41 80 80 80 80 78 67 0B
8 10 1 00000003 0 0 41 F8 AC D1 91 01 67 0B
4 10 1 00000020 0 0 41 00 68 0B
4 10 1 00000000 0 0 41 01 68 0B
8 10 1 0000001F 0 0 41 80 80 80 80 78 68 0B
8 10 1 00000003 0 0 41 F8 AC D1 91 01 68 0B
4 10 1 00000000 0 0 41 00 69 0B
4 10 1 00000020 0 0 41 7F 69 0B
8 10 1 00000001 0 0 41 80 80 80 80 78 69 0B
8 10 1 0000000D 0 0 41 F8 AC D1 91 01 69 0B
4 10 1 00000001 0 0 41 00 45 0B
4 10 1 00000000 0 0 41 01 45 0B
8 10 1 00000000 0 0 41 80 80 80 80 78 45 0B
// f32 values and reinterpret
9 10 5 00000000 0 0 41 01 43 00 00 80 3F 6A 0B
7 10 1 3F800000 0 0 43 00 00 80 3F BC 0B
4 10 1 00000005 2 0 41 05 BE 0B
// nop, drop and traps
5 10 1 00000009 0 0 01 41 09 01 0B
6 10 1 00000003 0 0 41 03 41 04 1A 0B
1 10 1 00000000 0 1 0B
2 10 3 00000000 0 1 1A 0B
1 10 2 00000000 0 1 00
2 10 7 00000000 0 1 FF 0B
2 10 6 00000000 0 0 41 05
// seventeen pushes
23 10 4 00000000 0 0
41 01 41 01 41 01 41 01 41 01 41 01 41 01 41 01
41 01 41 01 41 01 41 01 41 01 41 01 41 01 41 01
41 01 0B
0

/* dv/tb_checker.sv */
`timescale 1ns/100ps
`include "wasm_params.svh"

module tb_checker (
  input  logic                     clk,
  input  logic                     armed,
  input  int                       cycle_limit,
  input  logic                     report,
  input  logic [`WASM_TRAP_W-1:0]  trap,
  input  logic [`WASM_VALUE_W-1:0] result,
  input  logic [`WASM_TYPE_W-1:0]  result_type,
  input  logic                     result_empty,
  input  logic [`WASM_TRAP_W-1:0]  exp_trap,
  input  logic [`WASM_VALUE_W-1:0] exp_result,
  input  logic [`WASM_TYPE_W-1:0]  exp_type,
  input  logic                     exp_empty,
  output logic                     check_done,
  output logic                     timed_out,
  output logic                     reported,
  output int                       error_count
);

  int cycles;
  int test_count;

  function automatic string type_name(input logic [`WASM_TYPE_W-1:0] tag);
    case (tag)
      wasm_isa_pkg::TYPE_I32: return "i32";
      wasm_isa_pkg::TYPE_I64: return "i64";
      wasm_isa_pkg::TYPE_F32: return "f32";
      default:                return "f64";
    endcase
  endfunction

  task automatic compare_outcome();
    test_count++;
    if (trap !== exp_trap) begin
      error_count++;
      $display("error %0t: trap %0d, expected %0d", $time, trap, exp_trap);
    end
    if (result_empty !== exp_empty) begin
      error_count++;
      $display("error %0t: result_empty %b, expected %b", $time, result_empty, exp_empty);
    end
    // Top of stack only matters after a normal end
    if (exp_trap == wasm_core_pkg::TRAP_ENDED && !exp_empty) begin
      if (result !== exp_result) begin
        error_count++;
        $display("error %0t: result %h, expected %h", $time, result, exp_result);
      end
      if (result_type !== exp_type) begin
        error_count++;
        $display("error %0t: result type %s, expected %s", $time,
                 type_name(result_type), type_name(exp_type));
      end
    end
  endtask

  initial begin
    check_done  = 1'b0;
    timed_out   = 1'b0;
    reported    = 1'b0;
    error_count = 0;
    cycles      = 0;
    test_count  = 0;
  end

  // DUT state is sampled before the edge updates land
  always @(posedge clk) begin
    if (!armed) begin
      cycles     = 0;
      check_done = 1'b0;
    end else if (!check_done && !timed_out) begin
      cycles++;
      if (trap != wasm_core_pkg::TRAP_NONE) begin
        compare_outcome();
        check_done = 1'b1;
      end else if (cycles >= cycle_limit) begin
        timed_out = 1'b1;
        $display("timeout: the program never finished within %0d cycles", cycle_limit);
      end
    end
    if (report && !reported) begin
      $display("checker: %0d tests checked, %0d errors, %0d timeouts",
               test_count, error_count, int'(timed_out));
      reported = 1'b1;
    end
  end

endmodule

/* dv/tb_top.sv */
`timescale 1ns/100ps
`include "wasm_params.svh"

// Free-running 100 ns clock
module tb_clock (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

endmodule

module tb_top;

  localparam int GOLDEN_WORDS = 1024;
  localparam int ROM_BYTES    = 256;
  localparam int HEADER_WORDS = 6;

  logic                           clk;
  logic                           reset;
  logic [`WASM_ADDR_W-1:0]        start_pc;
  logic [8*`WASM_FETCH_BYTES-1:0] mem_data;
  logic                           mem_error;
  logic [`WASM_ADDR_W-1:0]        mem_addr;
  logic [`WASM_TRAP_W-1:0]        trap;
  logic [`WASM_VALUE_W-1:0]       result;
  logic [`WASM_TYPE_W-1:0]        result_type;
  logic                           result_empty;

  logic [31:0] golden [GOLDEN_WORDS];
  logic [7:0]  rom [ROM_BYTES];
  int          prog_end;

  // Expected outcome of the running program
  logic [`WASM_TRAP_W-1:0]  exp_trap;
  logic [`WASM_VALUE_W-1:0] exp_result;
  logic [`WASM_TYPE_W-1:0]  exp_type;
  logic                     exp_empty;

  logic armed;
  int   cycle_limit;
  logic report;
  logic check_done;
  logic timed_out;
  logic reported;
  int   error_count;

  tb_clock clock_i (
    .clk (clk)
  );

  wasm_core_top dut_i (
    .clk          (clk),
    .reset        (reset),
    .start_pc     (start_pc),
    .mem_data     (mem_data),
    .mem_error    (mem_error),
    .mem_addr     (mem_addr),
    .trap         (trap),
    .result       (result),
    .result_type  (result_type),
    .result_empty (result_empty)
  );

  tb_checker checker_i (
    .clk          (clk),
    .armed        (armed),
    .cycle_limit  (cycle_limit),
    .report       (report),
    .trap         (trap),
    .result       (result),
    .result_type  (result_type),
    .result_empty (result_empty),
    .exp_trap     (exp_trap),
    .exp_result   (exp_result),
    .exp_type     (exp_type),
    .exp_empty    (exp_empty),
    .check_done   (check_done),
    .timed_out    (timed_out),
    .reported     (reported),
    .error_count  (error_count)
  );

  // ROM window with the byte at mem_addr in the low lane
  always_comb begin
    for (int i = 0; i < `WASM_FETCH_BYTES; i++) begin
      if (int'(mem_addr) + i < ROM_BYTES)
        mem_data[8*i +: 8] = rom[8'(int'(mem_addr) + i)];
      else
        mem_data[8*i +: 8] = 8'h00;
    end
  end

  assign mem_error = (int'(mem_addr) >= prog_end);

  task automatic fill_rom();
    for (int a = 0; a < ROM_BYTES; a++)
      rom[8'(a)] = 8'(a) ^ 8'hA5;
  endtask

  task automatic load_program(input int base, input int nbytes, input int addr);
    fill_rom();
    for (int i = 0; i < nbytes; i++)
      rom[8'(addr + i)] = golden[10'(base + i)][7:0];
    prog_end = addr + nbytes;
  endtask

  initial begin
    int pos;
    int nbytes;
    int base_pc;
    int tests_run;
    reset       = 1'b1;
    start_pc    = '0;
    prog_end    = 0;
    armed       = 1'b0;
    report      = 1'b0;
    cycle_limit = 0;
    exp_trap    = '0;
    exp_result  = '0;
    exp_type    = '0;
    exp_empty   = 1'b0;
    fill_rom();
    $readmemh("dv/program_golden.mem", golden);
    pos       = 0;
    tests_run = 0;
    nbytes    = int'(golden[0]);
    @(negedge clk);
    // Zero byte count ends the record list
    while (nbytes != 0 && !timed_out) begin
      reset      = 1'b1;
      armed      = 1'b0;
      base_pc    = int'(golden[10'(pos + 1)]);
      start_pc   = golden[10'(pos + 1)][`WASM_ADDR_W-1:0];
      exp_trap   = golden[10'(pos + 2)][`WASM_TRAP_W-1:0];
      exp_result = golden[10'(pos + 3)];
      exp_type   = golden[10'(pos + 4)][`WASM_TYPE_W-1:0];
      exp_empty  = golden[10'(pos + 5)][0];
      load_program(pos + HEADER_WORDS, nbytes, base_pc);
      // Every instruction is at least one byte
      cycle_limit = 3 * nbytes + 20;
      repeat (3) @(negedge clk);
      reset = 1'b0;
      armed = 1'b1;
      while (!check_done && !timed_out)
        @(negedge clk);
      armed     = 1'b0;
      tests_run = tests_run + 1;
      pos       = pos + HEADER_WORDS + nbytes;
      nbytes    = int'(golden[10'(pos)]);
      @(negedge clk);
    end
    report = 1'b1;
    while (!reported)
      @(negedge clk);
    if (tests_run == 0)
      $display("no test records were read from the golden file");
    if (error_count == 0 && !timed_out && tests_run != 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

/* hw/i32_binary_alu.sv */
`timescale 1ns/100ps
`include "wasm_params.svh"

module i32_binary_alu (
  input  logic [7:0]                opcode,
  input  logic [`WASM_VALUE_W-1:0]  nos,
  input  logic [`WASM_VALUE_W-1:0]  tos,
  output logic [`WASM_VALUE_W-1:0]  alu_result
);

  logic [4:0]                 shamt;
  logic [2*`WASM_VALUE_W-1:0] rot_l;
  logic [2*`WASM_VALUE_W-1:0] rot_r;
  logic                       cmp;

  // Only the low five bits of the count matter
  assign shamt = tos[4:0];
  assign rot_l = {nos, nos} << shamt;
  assign rot_r = {nos, nos} >> shamt;

  always_comb begin
    case (opcode)
      wasm_isa_pkg::OP_I32_EQ:   cmp = (nos == tos);
      wasm_isa_pkg::OP_I32_NE:   cmp = (nos != tos);
      wasm_isa_pkg::OP_I32_LT_S: cmp = ($signed(nos) < $signed(tos));
      wasm_isa_pkg::OP_I32_LT_U: cmp = (nos < tos);
      wasm_isa_pkg::OP_I32_GT_S: cmp = ($signed(nos) > $signed(tos));
      wasm_isa_pkg::OP_I32_GT_U: cmp = (nos > tos);
      wasm_isa_pkg::OP_I32_LE_S: cmp = ($signed(nos) <= $signed(tos));
      wasm_isa_pkg::OP_I32_LE_U: cmp = (nos <= tos);
      wasm_isa_pkg::OP_I32_GE_S: cmp = ($signed(nos) >= $signed(tos));
      default:                   cmp = (nos >= tos);
    endcase
  end

  always_comb begin
    case (opcode)
      wasm_isa_pkg::OP_I32_ADD:   alu_result = nos + tos;
      wasm_isa_pkg::OP_I32_SUB:   alu_result = nos - tos;
      wasm_isa_pkg::OP_I32_MUL:   alu_result = nos * tos;
      wasm_isa_pkg::OP_I32_AND:   alu_result = nos & tos;
      wasm_isa_pkg::OP_I32_OR:    alu_result = nos | tos;
      wasm_isa_pkg::OP_I32_XOR:   alu_result = nos ^ tos;
      wasm_isa_pkg::OP_I32_SHL:   alu_result = nos << shamt;
      wasm_isa_pkg::OP_I32_SHR_S: alu_result = $signed(nos) >>> shamt;
      wasm_isa_pkg::OP_I32_SHR_U: alu_result = nos >> shamt;
      wasm_isa_pkg::OP_I32_ROTL:  alu_result = rot_l[2*`WASM_VALUE_W-1:`WASM_VALUE_W];
      wasm_isa_pkg::OP_I32_ROTR:  alu_result = rot_r[`WASM_VALUE_W-1:0];
      // Comparisons give 0 or 1
      default:                    alu_result = {{(`WASM_VALUE_W-1){1'b0}}, cmp};
    endcase
  end

endmodule

/* hw/i32_unary_unit.sv */
`timescale 1ns/100ps
`include "wasm_params.svh"

module i32_unary_unit (
  input  logic [7:0]                opcode,
  input  logic [`WASM_VALUE_W-1:0]  tos,
  output logic [`WASM_VALUE_W-1:0]  unary_result
);

  // Leading zeros by halving, zero input gives 32
  function automatic logic [5:0] clz32(input logic [31:0] v);
    logic [15:0] h;
    logic [7:0]  b;
    logic [3:0]  n;
    logic [5:0]  c;
    c = '0;
    if (v == '0)
      c = 6'd32;
    else begin
      c[4] = (v[31:16] == '0);
      h    = c[4] ? v[15:0] : v[31:16];
      c[3] = (h[15:8] == '0);
      b    = c[3] ? h[7:0] : h[15:8];
      c[2] = (b[7:4] == '0);
      n    = c[2] ? b[3:0] : b[7:4];
      c[1] = (n[3:2] == '0);
      c[0] = c[1] ? ~n[1] : ~n[3];
    end
    return c;
  endfunction

  // Same search from the low end
  function automatic logic [5:0] ctz32(input logic [31:0] v);
    logic [15:0] h;
    logic [7:0]  b;
    logic [3:0]  n;
    logic [5:0]  c;
    c = '0;
    if (v == '0)
      c = 6'd32;
    else begin
      c[4] = (v[15:0] == '0);
      h    = c[4] ? v[31:16] : v[15:0];
      c[3] = (h[7:0] == '0);
      b    = c[3] ? h[15:8] : h[7:0];
      c[2] = (b[3:0] == '0);
      n    = c[2] ? b[7:4] : b[3:0];
      c[1] = (n[1:0] == '0);
      c[0] = c[1] ? ~n[2] : ~n[0];
    end
    return c;
  endfunction

  function automatic logic [5:0] popcnt32(input logic [31:0] v);
    logic [5:0] c;
    c = '0;
    for (int i = 0; i < 32; i++)
      c = c + {5'b0, v[i]};
    return c;
  endfunction

  always_comb begin
    case (opcode)
      wasm_isa_pkg::OP_I32_CLZ:    unary_result = {26'b0, clz32(tos)};
      wasm_isa_pkg::OP_I32_CTZ:    unary_result = {26'b0, ctz32(tos)};
      wasm_isa_pkg::OP_I32_POPCNT: unary_result = {26'b0, popcnt32(tos)};
      // eqz
      default:                     unary_result = {31'b0, tos == '0};
    endcase
  end

endmodule

/* hw/instr_sequencer.sv */
`timescale 1ns/100ps
`include "wasm_params.svh"

module instr_sequencer (
  input  logic                            clk,
  input  logic                            reset,
  input  logic [`WASM_ADDR_W-1:0]         start_pc,
  input  logic [8*`WASM_FETCH_BYTES-1:0]  mem_data,
  input  logic                            mem_error,
  input  logic [`WASM_VALUE_W-1:0]        tos,
  input  logic [`WASM_TYPE_W-1:0]         tos_type,
  input  logic [`WASM_TYPE_W-1:0]         nos_type,
  input  logic [`WASM_STACK_DEPTH_LOG2:0] count,
  input  logic [`WASM_VALUE_W-1:0]        alu_result,
  input  logic [`WASM_VALUE_W-1:0]        unary_result,
  output logic [`WASM_ADDR_W-1:0]         mem_addr,
  output logic [7:0]                      opcode,
  output logic [2:0]                      stack_op,
  output logic [`WASM_VALUE_W-1:0]        stack_data,
  output logic [`WASM_TYPE_W-1:0]         stack_type,
  output logic [`WASM_TRAP_W-1:0]         trap
);

  localparam int unsigned ADDR_W    = `WASM_ADDR_W;
  localparam int unsigned IMM_BYTES = `WASM_FETCH_BYTES - 1;
  localparam int unsigned LOG2      = `WASM_STACK_DEPTH_LOG2;

  localparam logic [1:0] FETCH = 2'd0;
  localparam logic [1:0] CHECK = 2'd1;
  localparam logic [1:0] EXEC  = 2'd2;

  logic [1:0]               step;
  logic [ADDR_W-1:0]        pc;
  logic [8*IMM_BYTES-1:0]   imm_bytes;
  logic [`WASM_VALUE_W-1:0] leb_value;
  logic [2:0]               leb_len;
  logic                     leb_done;
  logic                     is_push;

  logic [2:0]               exec_op;
  logic [`WASM_VALUE_W-1:0] exec_data;
  logic [`WASM_TYPE_W-1:0]  exec_type;
  logic [`WASM_TRAP_W-1:0]  exec_trap;
  logic [`WASM_TYPE_W-1:0]  need_tag;
  logic                     need_one;
  logic                     need_two;
  logic                     check_tag;
  logic [ADDR_W-1:0]        imm_len;
  logic                     too_few;
  logic                     bad_tag;

  // Immediate bytes follow the opcode in the fetch window
  assign imm_bytes = mem_data[8*`WASM_FETCH_BYTES-1:8];

  // Signed LEB128, up to five bytes for a 32-bit value
  always_comb begin
    leb_value = '0;
    leb_len   = 3'd5;
    leb_done  = 1'b0;
    for (int i = 0; i < IMM_BYTES; i++) begin
      if (!leb_done) begin
        leb_value = leb_value | (32'(imm_bytes[8*i +: 7]) << (7 * i));
        if (!imm_bytes[8*i + 7]) begin
          leb_done = 1'b1;
          leb_len  = 3'(i + 1);
          // Sign bit of the last group fills the rest
          if (imm_bytes[8*i + 6] && i < IMM_BYTES - 1)
            leb_value = leb_value | ('1 << (7 * (i + 1)));
        end
      end
    end
  end

  // Decode and result combining for the latched opcode
  always_comb begin
    exec_op   = wasm_core_pkg::SOP_NONE;
    exec_data = tos;
    exec_type = wasm_isa_pkg::TYPE_I32;
    exec_trap = wasm_core_pkg::TRAP_NONE;
    need_tag  = wasm_isa_pkg::TYPE_I32;
    need_one  = 1'b0;
    need_two  = 1'b0;
    check_tag = 1'b0;
    imm_len   = '0;
    case (opcode)
      wasm_isa_pkg::OP_UNREACHABLE: exec_trap = wasm_core_pkg::TRAP_UNREACHABLE;
      wasm_isa_pkg::OP_NOP:         exec_op = wasm_core_pkg::SOP_NONE;
      wasm_isa_pkg::OP_END:         exec_trap = wasm_core_pkg::TRAP_ENDED;
      wasm_isa_pkg::OP_DROP: begin
        exec_op  = wasm_core_pkg::SOP_POP;
        need_one = 1'b1;
      end
      wasm_isa_pkg::OP_I32_CONST: begin
        exec_op   = wasm_core_pkg::SOP_PUSH;
        exec_data = leb_value;
        imm_len   = ADDR_W'(leb_len);
      end
      wasm_isa_pkg::OP_F32_CONST: begin
        // Raw little-endian bits, no decoding
        exec_op   = wasm_core_pkg::SOP_PUSH;
        exec_data = imm_bytes[31:0];
        exec_type = wasm_isa_pkg::TYPE_F32;
        imm_len   = ADDR_W'(4);
      end
      wasm_isa_pkg::OP_I32_EQZ, wasm_isa_pkg::OP_I32_CLZ,
      wasm_isa_pkg::OP_I32_CTZ, wasm_isa_pkg::OP_I32_POPCNT: begin
        exec_op   = wasm_core_pkg::SOP_REPLACE;
        exec_data = unary_result;
        need_one  = 1'b1;
        check_tag = 1'b1;
      end
      wasm_isa_pkg::OP_I32_EQ, wasm_isa_pkg::OP_I32_NE, wasm_isa_pkg::OP_I32_LT_S,
      wasm_isa_pkg::OP_I32_LT_U, wasm_isa_pkg::OP_I32_GT_S, wasm_isa_pkg::OP_I32_GT_U,
      wasm_isa_pkg::OP_I32_LE_S, wasm_isa_pkg::OP_I32_LE_U, wasm_isa_pkg::OP_I32_GE_S,
      wasm_isa_pkg::OP_I32_GE_U, wasm_isa_pkg::OP_I32_ADD, wasm_isa_pkg::OP_I32_SUB,
      wasm_isa_pkg::OP_I32_MUL, wasm_isa_pkg::OP_I32_AND, wasm_isa_pkg::OP_I32_OR,
      wasm_isa_pkg::OP_I32_XOR, wasm_isa_pkg::OP_I32_SHL, wasm_isa_pkg::OP_I32_SHR_S,
      wasm_isa_pkg::OP_I32_SHR_U, wasm_isa_pkg::OP_I32_ROTL,
      wasm_isa_pkg::OP_I32_ROTR: begin
        exec_op   = wasm_core_pkg::SOP_POP2_PUSH;
        exec_data = alu_result;
        need_two  = 1'b1;
        check_tag = 1'b1;
      end
      wasm_isa_pkg::OP_I32_REINTERPRET_F32: begin
        exec_op   = wasm_core_pkg::SOP_REPLACE;
        need_one  = 1'b1;
        check_tag = 1'b1;
        need_tag  = wasm_isa_pkg::TYPE_F32;
      end
      wasm_isa_pkg::OP_F32_REINTERPRET_I32: begin
        exec_op   = wasm_core_pkg::SOP_REPLACE;
        exec_type = wasm_isa_pkg::TYPE_F32;
        need_one  = 1'b1;
        check_tag = 1'b1;
      end
      default: exec_trap = wasm_core_pkg::TRAP_UNKNOWN_OPCODE;
    endcase
  end

  // Operand count and tag checks
  assign too_few = need_two ? (count[LOG2:1] == '0) : (need_one && count == '0);
  assign bad_tag = check_tag &&
                   (tos_type != need_tag || (need_two && nos_type != need_tag));

  assign is_push = (mem_data[7:0] == wasm_isa_pkg::OP_I32_CONST) ||
                   (mem_data[7:0] == wasm_isa_pkg::OP_F32_CONST);

  always_ff @(posedge clk) begin
    if (reset) begin
      step     <= FETCH;
      pc       <= start_pc;
      mem_addr <= start_pc;
      trap     <= wasm_core_pkg::TRAP_NONE;
      stack_op <= wasm_core_pkg::SOP_NONE;
    end else begin
      stack_op <= wasm_core_pkg::SOP_NONE;
      if (trap == wasm_core_pkg::TRAP_NONE) begin
        case (step)
          FETCH: begin
            mem_addr <= pc;
            step     <= CHECK;
          end
          CHECK: begin
            step <= EXEC;
            if (mem_error)
              trap <= wasm_core_pkg::TRAP_MEM_ERROR;
            // Top count bit set means all entries are in use
            else if (count[LOG2] && is_push)
              trap <= wasm_core_pkg::TRAP_STACK_FULL;
          end
          EXEC: begin
            step <= FETCH;
            if (exec_trap != wasm_core_pkg::TRAP_NONE)
              trap <= exec_trap;
            else if (too_few)
              trap <= wasm_core_pkg::TRAP_STACK_EMPTY;
            else if (bad_tag)
              trap <= wasm_core_pkg::TRAP_TYPE_MISMATCH;
            else begin
              stack_op <= exec_op;
              pc       <= pc + imm_len + ADDR_W'(1);
            end
          end
          default: step <= FETCH;
        endcase
      end
    end
  end

  // Opcode and stack write payload
  always_ff @(posedge clk) begin
    if (step == CHECK)
      opcode <= mem_data[7:0];
    if (step == EXEC) begin
      stack_data <= exec_data;
      stack_type <= exec_type;
    end
  end

endmodule

/* hw/operand_stack.sv */
`timescale 1ns/100ps
`include "wasm_params.svh"

module operand_stack (
  input  logic                            clk,
  input  logic                            reset,
  input  logic [2:0]                      stack_op,
  input  logic [`WASM_VALUE_W-1:0]        stack_data,
  input  logic [`WASM_TYPE_W-1:0]         stack_type,
  output logic [`WASM_VALUE_W-1:0]        tos,
  output logic [`WASM_TYPE_W-1:0]         tos_type,
  output logic [`WASM_VALUE_W-1:0]        nos,
  output logic [`WASM_TYPE_W-1:0]         nos_type,
  output logic [`WASM_STACK_DEPTH_LOG2:0] count
);

  localparam int unsigned LOG2  = `WASM_STACK_DEPTH_LOG2;
  localparam int unsigned DEPTH = 1 << LOG2;

  logic [`WASM_VALUE_W-1:0] values [DEPTH];
  logic [`WASM_TYPE_W-1:0]  types  [DEPTH];
  logic [LOG2-1:0]          top_idx;
  logic [LOG2-1:0]          nos_idx;
  logic [LOG2-1:0]          wr_idx;
  logic                     wr_en;

  // Indices wrap when the stack is shallow, outputs are then don't care
  assign top_idx = count[LOG2-1:0] - 1'b1;
  assign nos_idx = count[LOG2-1:0] - 2'd2;

  always_comb begin
    wr_en  = 1'b1;
    wr_idx = count[LOG2-1:0];
    case (stack_op)
      wasm_core_pkg::SOP_PUSH:      wr_idx = count[LOG2-1:0];
      wasm_core_pkg::SOP_REPLACE:   wr_idx = top_idx;
      wasm_core_pkg::SOP_POP2_PUSH: wr_idx = nos_idx;
      default:                      wr_en  = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      values[wr_idx] <= stack_data;
      types[wr_idx]  <= stack_type;
    end
  end

  always_ff @(posedge clk) begin
    if (reset)
      count <= '0;
    else begin
      case (stack_op)
        wasm_core_pkg::SOP_PUSH:      count <= count + 1'b1;
        wasm_core_pkg::SOP_POP,
        wasm_core_pkg::SOP_POP2_PUSH: count <= count - 1'b1;
        default:                      count <= count;
      endcase
    end
  end

  assign tos      = values[top_idx];
  assign tos_type = types[top_idx];
  assign nos      = values[nos_idx];
  assign nos_type = types[nos_idx];

endmodule

/* hw/wasm_core_pkg.sv */
`include "wasm_params.svh"

package wasm_core_pkg;

  // Trap codes, non-zero halts the core
  localparam logic [`WASM_TRAP_W-1:0] TRAP_NONE           = 4'd0;
  localparam logic [`WASM_TRAP_W-1:0] TRAP_ENDED          = 4'd1;
  localparam logic [`WASM_TRAP_W-1:0] TRAP_UNREACHABLE    = 4'd2;
  localparam logic [`WASM_TRAP_W-1:0] TRAP_STACK_EMPTY    = 4'd3;
  localparam logic [`WASM_TRAP_W-1:0] TRAP_STACK_FULL     = 4'd4;
  localparam logic [`WASM_TRAP_W-1:0] TRAP_TYPE_MISMATCH  = 4'd5;
  localparam logic [`WASM_TRAP_W-1:0] TRAP_MEM_ERROR      = 4'd6;
  localparam logic [`WASM_TRAP_W-1:0] TRAP_UNKNOWN_OPCODE = 4'd7;

  // Operand stack operations
  localparam logic [2:0] SOP_NONE      = 3'd0;
  localparam logic [2:0] SOP_PUSH      = 3'd1;
  localparam logic [2:0] SOP_POP       = 3'd2;
  localparam logic [2:0] SOP_REPLACE   = 3'd3;
  // Two operands out, one result in
  localparam logic [2:0] SOP_POP2_PUSH = 3'd4;

endpackage

/* hw/wasm_core_top.sv */
`timescale 1ns/100ps
`include "wasm_params.svh"

module wasm_core_top (
  input  logic                           clk,
  input  logic                           reset,
  input  logic [`WASM_ADDR_W-1:0]        start_pc,
  input  logic [8*`WASM_FETCH_BYTES-1:0] mem_data,
  input  logic                           mem_error,
  output logic [`WASM_ADDR_W-1:0]        mem_addr,
  output logic [`WASM_TRAP_W-1:0]        trap,
  output logic [`WASM_VALUE_W-1:0]       result,
  output logic [`WASM_TYPE_W-1:0]        result_type,
  output logic                           result_empty
);

  logic [7:0]                      opcode;
  logic [2:0]                      stack_op;
  logic [`WASM_VALUE_W-1:0]        stack_data;
  logic [`WASM_TYPE_W-1:0]         stack_type;
  logic [`WASM_VALUE_W-1:0]        tos;
  logic [`WASM_TYPE_W-1:0]         tos_type;
  logic [`WASM_VALUE_W-1:0]        nos;
  logic [`WASM_TYPE_W-1:0]         nos_type;
  logic [`WASM_STACK_DEPTH_LOG2:0] count;
  logic [`WASM_VALUE_W-1:0]        alu_result;
  logic [`WASM_VALUE_W-1:0]        unary_result;

  instr_sequencer sequencer_i (
    .clk          (clk),
    .reset        (reset),
    .start_pc     (start_pc),
    .mem_data     (mem_data),
    .mem_error    (mem_error),
    .tos          (tos),
    .tos_type     (tos_type),
    .nos_type     (nos_type),
    .count        (count),
    .alu_result   (alu_result),
    .unary_result (unary_result),
    .mem_addr     (mem_addr),
    .opcode       (opcode),
    .stack_op     (stack_op),
    .stack_data   (stack_data),
    .stack_type   (stack_type),
    .trap         (trap)
  );

  operand_stack stack_i (
    .clk        (clk),
    .reset      (reset),
    .stack_op   (stack_op),
    .stack_data (stack_data),
    .stack_type (stack_type),
    .tos        (tos),
    .tos_type   (tos_type),
    .nos        (nos),
    .nos_type   (nos_type),
    .count      (count)
  );

  i32_binary_alu alu_i (
    .opcode     (opcode),
    .nos        (nos),
    .tos        (tos),
    .alu_result (alu_result)
  );

  i32_unary_unit unary_i (
    .opcode       (opcode),
    .tos          (tos),
    .unary_result (unary_result)
  );

  // Result is whatever sits on top when the program ends
  assign result       = tos;
  assign result_type  = tos_type;
  assign result_empty = (count == '0);

endmodule

/* hw/wasm_isa_pkg.sv */
`include "wasm_params.svh"

package wasm_isa_pkg;

  // Control and parametric opcodes
  localparam logic [7:0] OP_UNREACHABLE = 8'h00;
  localparam logic [7:0] OP_NOP         = 8'h01;
  localparam logic [7:0] OP_END         = 8'h0B;
  localparam logic [7:0] OP_DROP        = 8'h1A;

  // Constants
  localparam logic [7:0] OP_I32_CONST = 8'h41;
  localparam logic [7:0] OP_F32_CONST = 8'h43;

  // Test and comparisons
  localparam logic [7:0] OP_I32_EQZ  = 8'h45;
  localparam logic [7:0] OP_I32_EQ   = 8'h46;
  localparam logic [7:0] OP_I32_NE   = 8'h47;
  localparam logic [7:0] OP_I32_LT_S = 8'h48;
  localparam logic [7:0] OP_I32_LT_U = 8'h49;
  localparam logic [7:0] OP_I32_GT_S = 8'h4A;
  localparam logic [7:0] OP_I32_GT_U = 8'h4B;
  localparam logic [7:0] OP_I32_LE_S = 8'h4C;
  localparam logic [7:0] OP_I32_LE_U = 8'h4D;
  localparam logic [7:0] OP_I32_GE_S = 8'h4E;
  localparam logic [7:0] OP_I32_GE_U = 8'h4F;

  // Numeric
  localparam logic [7:0] OP_I32_CLZ    = 8'h67;
  localparam logic [7:0] OP_I32_CTZ    = 8'h68;
  localparam logic [7:0] OP_I32_POPCNT = 8'h69;
  localparam logic [7:0] OP_I32_ADD    = 8'h6A;
  localparam logic [7:0] OP_I32_SUB    = 8'h6B;
  localparam logic [7:0] OP_I32_MUL    = 8'h6C;
  localparam logic [7:0] OP_I32_AND    = 8'h71;
  localparam logic [7:0] OP_I32_OR     = 8'h72;
  localparam logic [7:0] OP_I32_XOR    = 8'h73;
  localparam logic [7:0] OP_I32_SHL    = 8'h74;
  localparam logic [7:0] OP_I32_SHR_S  = 8'h75;
  localparam logic [7:0] OP_I32_SHR_U  = 8'h76;
  localparam logic [7:0] OP_I32_ROTL   = 8'h77;
  localparam logic [7:0] OP_I32_ROTR   = 8'h78;

  // Reinterpretations
  localparam logic [7:0] OP_I32_REINTERPRET_F32 = 8'hBC;
  localparam logic [7:0] OP_F32_REINTERPRET_I32 = 8'hBE;

  // Value type tags
  localparam logic [`WASM_TYPE_W-1:0] TYPE_I32 = 2'd0;
  localparam logic [`WASM_TYPE_W-1:0] TYPE_I64 = 2'd1;
  localparam logic [`WASM_TYPE_W-1:0] TYPE_F32 = 2'd2;
  localparam logic [`WASM_TYPE_W-1:0] TYPE_F64 = 2'd3;

endpackage

/* hw/wasm_params.svh */
`ifndef WASM_PARAMS_SVH
`define WASM_PARAMS_SVH

// Program memory byte address
`define WASM_ADDR_W 16

// Opcode plus the longest 32-bit varint
`define WASM_FETCH_BYTES 6

// 16 operand stack entries
`define WASM_STACK_DEPTH_LOG2 4

`define WASM_VALUE_W 32
`define WASM_TYPE_W 2
`define WASM_TRAP_W 4

`endif

/* run.sh */
#!/bin/sh
# Build with Verilator and run from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing -f compile.f --top-module tb_top -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -q "All tests passed!" &&
echo "PASS" && exit 0 ||
{ echo "FAIL"; exit 1; }
